// ==== Bender.yml ====
package:
  name: fetch_buffer

sources:
  - fetch_pkg.sv
  - line_ram.sv
  - line_fifo.sv
  - line_fetch_ctrl.sv
  - fetch_buffer.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_icache_model.sv
      - tb_fetch_top.sv

// ==== fetch_buffer.sv ====
module fetch_buffer
  import fetch_pkg::*;
#(
  parameter int                DEPTH    = 4,
  parameter logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [ADDR_W-1:0]      pc_i,
  input  logic                   jmp_flush_i,
  input  logic [LINE_W-1:0]      head_i,
  input  logic                   empty_i,
  input  logic [$clog2(DEPTH):0] count_i,
  input  logic                   bypass_i,
  output logic                   pop_o,
  output logic [ADDR_W-1:0]      req_addr_o,
  output logic                   inst_valid_o,
  output logic [INST_W-1:0]      inst_o
);

  localparam int WORDS = LINE_W / INST_W;

  logic [LINE_ADDR_W-1:0] cur_line_q;
  logic [LINE_ADDR_W-1:0] pc_line;
  logic [LINE_ADDR_W-1:0] next_line;
  logic                   line_same;
  logic [INST_W-1:0]      head_word;

  // ======================================================================
  // current line tracking
  // ======================================================================

  assign pc_line   = pc_i[ADDR_W-1:LINE_OFS_W];
  assign line_same = (pc_line == cur_line_q);

  // the head of the fifo always holds cur_line_q when not empty
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cur_line_q <= RESET_PC[ADDR_W-1:LINE_OFS_W];
    end else if (!line_same) begin
      cur_line_q <= pc_line;
    end
  end

  // head line is done once pc leaves it
  assign pop_o = ~line_same & ~empty_i;

  // ======================================================================
  // prefetch address
  // ======================================================================

  // next missing line sits count_i lines past the current one
  always_comb begin
    if (jmp_flush_i) begin
      next_line = pc_line;
    end else begin
      next_line = cur_line_q + LINE_ADDR_W'(count_i);
    end
  end

  assign req_addr_o = {next_line, {LINE_OFS_W{1'b0}}};

  // ======================================================================
  // instruction select
  // ======================================================================

  // an empty fifo still serves the line arriving this cycle
  assign inst_valid_o = line_same & (~empty_i | bypass_i);

  always_comb begin
    head_word = '0;
    for (int k = 0; k < WORDS; k++) begin
      if (pc_i[LINE_OFS_W-1:2] == k) begin
        head_word = head_i[k*INST_W +: INST_W];
      end
    end
  end

  assign inst_o = inst_valid_o ? head_word : '0;

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

  // ======================================================================
  // address and data widths
  // ======================================================================

  // byte address
  localparam int ADDR_W = 32;

  // one instruction word
  localparam int INST_W = 32;

  // one cache line, four instruction words
  localparam int LINE_W = 128;

  // byte offset inside a line
  localparam int LINE_OFS_W = 4;

  // line address, byte offset stripped
  localparam int LINE_ADDR_W = ADDR_W - LINE_OFS_W;

  // ======================================================================
  // read channel state
  // ======================================================================

  // idle: address may go out, wait_data: one read outstanding
  typedef enum logic {
    RD_IDLE      = 1'b0,
    RD_WAIT_DATA = 1'b1
  } rd_state_e;

endpackage

// ==== fetch_top.sv ====
module fetch_top
  import fetch_pkg::*;
#(
  parameter int                DEPTH    = 4,
  parameter logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ar_ready_i,
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  input  logic              r_valid_i,
  input  logic [LINE_W-1:0] r_data_i,
  output logic              r_ready_o,
  input  logic              jmp_flush_i,
  input  logic [ADDR_W-1:0] pc_i,
  output logic              inst_valid_o,
  output logic [INST_W-1:0] inst_o
);

  logic [ADDR_W-1:0]      req_addr;
  logic                   line_wr;
  logic                   line_pop;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic [LINE_W-1:0]      head_line;
  logic [$clog2(DEPTH):0] fifo_count;

  fetch_buffer #(
    .DEPTH    (DEPTH),
    .RESET_PC (RESET_PC)
  ) fetch_buffer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .head_i       (head_line),
    .empty_i      (fifo_empty),
    .count_i      (fifo_count),
    .bypass_i     (line_wr),
    .pop_o        (line_pop),
    .req_addr_o   (req_addr),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

  line_fetch_ctrl line_fetch_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .fifo_full_i (fifo_full),
    .jmp_flush_i (jmp_flush_i),
    .req_addr_i  (req_addr),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .r_ready_o   (r_ready_o),
    .line_wr_o   (line_wr)
  );

  line_fifo #(
    .DEPTH (DEPTH)
  ) line_fifo_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (line_wr),
    .push_data_i (r_data_i),
    .pop_i       (line_pop),
    .flush_i     (jmp_flush_i),
    .head_o      (head_line),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .count_o     (fifo_count)
  );

endmodule

// ==== line_fetch_ctrl.sv ====
module line_fetch_ctrl
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ar_ready_i,
  input  logic              r_valid_i,
  input  logic              fifo_full_i,
  input  logic              jmp_flush_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  output logic              r_ready_o,
  output logic              line_wr_o
);

  rd_state_e         state_q;
  rd_state_e         state_d;
  logic              r_ready_q;
  logic              discard_q;
  logic              pend_q;
  logic              run_q;
  logic [ADDR_W-1:0] addr_q;
  logic              ar_fire;
  logic              r_fire;

  // ======================================================================
  // address phase
  // ======================================================================

  // first request goes out one cycle after reset is released
  always_ff @(posedge clk) begin
    if (rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // flush empties the fifo this cycle, so full does not block it
  assign ar_valid_o = run_q & (state_q == RD_IDLE) & (~fifo_full_i | jmp_flush_i);
  assign ar_fire    = ar_valid_o & ar_ready_i;

  // a stalled address stays put until a flush swaps in the new target
  assign ar_addr_o = (pend_q & ~jmp_flush_i) ? addr_q : req_addr_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= ar_valid_o & ~ar_ready_i;
    end
  end

  always_ff @(posedge clk) begin
    addr_q <= ar_addr_o;
  end

  // ======================================================================
  // data phase
  // ======================================================================

  assign r_ready_o = r_ready_q;
  assign r_fire    = r_valid_i & r_ready_q;

  // beats of a read overtaken by a flush are dropped
  assign line_wr_o = r_fire & ~discard_q & ~jmp_flush_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (ar_fire) begin
          state_d = RD_WAIT_DATA;
        end
      end
      RD_WAIT_DATA: begin
        if (r_fire) begin
          state_d = RD_IDLE;
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q   <= RD_IDLE;
      r_ready_q <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      r_ready_q <= (state_d == RD_WAIT_DATA);
      if (r_fire) begin
        discard_q <= 1'b0;
      end else if ((state_q == RD_WAIT_DATA) && jmp_flush_i) begin
        discard_q <= 1'b1;
      end
    end
  end

endmodule

// ==== line_fifo.sv ====
module line_fifo
  import fetch_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  logic [LINE_W-1:0]      push_data_i,
  input  logic                   pop_i,
  input  logic                   flush_i,
  output logic [LINE_W-1:0]      head_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic [$clog2(DEPTH):0] count_o
);

  localparam int IDX_W = $clog2(DEPTH);

  // extra msb tells full from empty
  logic [IDX_W:0] wr_ptr_q;
  logic [IDX_W:0] rd_ptr_q;
  logic           push_ok;
  logic           pop_ok;

  assign empty_o = (rd_ptr_q == wr_ptr_q);
  assign full_o  = (rd_ptr_q == {~wr_ptr_q[IDX_W], wr_ptr_q[IDX_W-1:0]});
  assign count_o = wr_ptr_q - rd_ptr_q;

  // nothing enters or leaves during a flush
  assign push_ok = push_i & ~full_o & ~flush_i;
  assign pop_ok  = pop_i & ~empty_o & ~flush_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
    end else if (push_ok) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // flush drops every buffered line
  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= wr_ptr_q;
    end else if (pop_ok) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  line_ram #(
    .DEPTH (DEPTH)
  ) line_ram_i (
    .clk       (clk),
    .wr_en_i   (push_ok),
    .wr_idx_i  (wr_ptr_q[IDX_W-1:0]),
    .wr_data_i (push_data_i),
    .rd_idx_i  (rd_ptr_q[IDX_W-1:0]),
    .rd_data_o (head_o)
  );

endmodule

// ==== line_ram.sv ====
module line_ram
  import fetch_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
  input  logic [LINE_W-1:0]        wr_data_i,
  input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
  output logic [LINE_W-1:0]        rd_data_o
);

  logic [LINE_W-1:0] mem_q [DEPTH];

  // line storage, written at the edge
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_data_i;
    end
  end

  // forward the incoming line so it can be used in its arrival cycle
  always_comb begin
    if (wr_en_i && (wr_idx_i == rd_idx_i)) begin
      rd_data_o = wr_data_i;
    end else begin
      rd_data_o = mem_q[rd_idx_i];
    end
  end

endmodule

// ==== tb.f ====
fetch_pkg.sv
line_ram.sv
line_fifo.sv
line_fetch_ctrl.sv
fetch_buffer.sv
fetch_top.sv
tb_icache_model.sv
tb_fetch_top.sv

// ==== tb_fetch_top.sv ====
module tb_fetch_top
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                DEPTH      = 4;
  localparam logic [ADDR_W-1:0] RESET_PC   = 32'h8000_0000;
  localparam int                CLK_PERIOD = 40;
  localparam int                N_SEQ      = 64;
  localparam int                N_DEPTH    = 32;
  localparam int                N_JUMP     = 10;
  localparam int                N_RAND     = 200;
  localparam int                PAUSE      = 20;
  localparam int                MAX_CPI    = 40;
  localparam int                WD_CYCLES  =
    (N_SEQ + N_DEPTH + N_JUMP + N_RAND) * MAX_CPI + 4 * PAUSE + 100;

  logic              clk;
  logic              rst_n;
  logic              ar_ready;
  logic              ar_valid;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  logic [LINE_W-1:0] r_data;
  logic              r_ready;
  logic              jmp_flush;
  logic [ADDR_W-1:0] pc;
  logic              inst_valid;
  logic [INST_W-1:0] inst;
  logic              rdy_rand;
  logic [1:0]        dly_rand;
  int                acc_cnt;
  logic [ADDR_W-1:0] acc_addr;

  // ======================================================================
  // testbench state
  // ======================================================================

  logic [31:0]            lfsr_q;
  logic                   rand_mode;
  logic [1:0]             fix_delay;
  logic [ADDR_W-1:0]      cur_pc;
  logic [ADDR_W-1:0]      last_pc;
  logic [ADDR_W-1:0]      last_acc;
  logic                   jump_pend;
  logic [LINE_ADDR_W-1:0] jump_line;
  int                     seen_cnt;
  int                     check_cnt;
  int                     err_cnt;
  int                     test_checks;
  int                     test_errs;
  string                  cur_test;

  fetch_top #(
    .DEPTH    (DEPTH),
    .RESET_PC (RESET_PC)
  ) fetch_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_ready_i   (ar_ready),
    .ar_valid_o   (ar_valid),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_data_i     (r_data),
    .r_ready_o    (r_ready),
    .jmp_flush_i  (jmp_flush),
    .pc_i         (pc),
    .inst_valid_o (inst_valid),
    .inst_o       (inst)
  );

  tb_icache_model cache_model_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rdy_i      (rdy_rand),
    .delay_i    (dly_rand),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_ready_i  (r_ready),
    .acc_cnt_o  (acc_cnt),
    .acc_addr_o (acc_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Finished with errors");
    $finish;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_cnt = check_cnt + 1;
    if (exp !== act) begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH %s (%s): expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_checks = check_cnt;
    test_errs   = err_cnt;
  endtask

  task automatic report_test();
    $display("%s: %0d checks, %0d errors", cur_test, check_cnt - test_checks,
             err_cnt - test_errs);
  endtask

  // drive one clock on the falling edge and look at the settled outputs
  task automatic drive_cycle(input logic [ADDR_W-1:0] pc_val, input logic flush);
    int ahead;
    @(negedge clk);
    pc        = pc_val;
    jmp_flush = flush;
    if (rand_mode) begin
      rdy_rand = 1'(rand_bits(1));
      dly_rand = 2'(rand_bits(2));
    end else begin
      rdy_rand = 1'b1;
      dly_rand = fix_delay;
    end
    #1;
    // address taken by the cache at the last rising edge
    if (acc_cnt != seen_cnt) begin
      seen_cnt = acc_cnt;
      if (jump_pend) begin
        check_value("first line after jump", {jump_line, 4'h0}, acc_addr);
      end else begin
        check_value("consecutive line", last_acc + 32'd16, acc_addr);
      end
      ahead = int'(acc_addr[ADDR_W-1:LINE_OFS_W]) - int'(last_pc[ADDR_W-1:LINE_OFS_W]);
      check_value("lines ahead within depth", 32'd1, 32'(ahead <= DEPTH));
      jump_pend = 1'b0;
      last_acc  = acc_addr;
    end
    if (flush) begin
      jump_pend = 1'b1;
      jump_line = pc_val[ADDR_W-1:LINE_OFS_W];
    end
    if (inst_valid) begin
      check_value("instruction equals pc", pc_val, inst);
    end else begin
      check_value("instruction zero while invalid", 32'd0, inst);
    end
    last_pc = pc_val;
  endtask

  task automatic fetch_inst(input logic [ADDR_W-1:0] pc_val, input logic flush);
    drive_cycle(pc_val, flush);
    while (!inst_valid) begin
      drive_cycle(pc_val, 1'b0);
    end
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic reset_check();
    begin_test("reset");
    @(negedge clk);
    #1;
    check_value("ar_valid_o in reset", 32'd0, 32'(ar_valid));
    check_value("r_ready_o in reset", 32'd0, 32'(r_ready));
    check_value("inst_valid_o in reset", 32'd0, 32'(inst_valid));
    @(negedge clk);
    rst_n = 1'b0;
    #1;
    check_value("ar_valid_o after reset", 32'd0, 32'(ar_valid));
    check_value("r_ready_o after reset", 32'd0, 32'(r_ready));
    check_value("inst_valid_o after reset", 32'd0, 32'(inst_valid));
    // first accepted line is checked against RESET_PC
    while (seen_cnt == 0) begin
      drive_cycle(cur_pc, 1'b0);
    end
    report_test();
  endtask

  task automatic sequential_fetch();
    begin_test("sequential fetch");
    repeat (N_SEQ) begin
      fetch_inst(cur_pc, 1'b0);
      cur_pc = cur_pc + 32'd4;
    end
    report_test();
  endtask

  task automatic prefetch_depth();
    begin_test("prefetch depth");
    repeat (N_DEPTH / 2) begin
      fetch_inst(cur_pc, 1'b0);
      cur_pc = cur_pc + 32'd4;
    end
    repeat (PAUSE) drive_cycle(cur_pc, 1'b0);
    check_value("no request with full fifo", 32'd0, 32'(ar_valid));
    repeat (N_DEPTH / 2) begin
      fetch_inst(cur_pc, 1'b0);
      cur_pc = cur_pc + 32'd4;
    end
    report_test();
  endtask

  task automatic jump_flush();
    begin_test("jump flush");
    fix_delay = 2'd2;
    repeat (PAUSE) drive_cycle(cur_pc, 1'b0);
    check_value("no read outstanding", 32'd0, 32'(r_ready));
    cur_pc = cur_pc + 32'h0000_4000;
    fetch_inst(cur_pc, 1'b1);
    // now jump again with a line read in flight
    while (!(r_ready && !r_valid)) begin
      drive_cycle(cur_pc, 1'b0);
    end
    cur_pc = cur_pc + 32'h0002_0008;
    fetch_inst(cur_pc, 1'b1);
    repeat (N_JUMP - 2) begin
      cur_pc = cur_pc + 32'd4;
      fetch_inst(cur_pc, 1'b0);
    end
    report_test();
  endtask

  task automatic random_stalls();
    begin_test("random stalls");
    rand_mode = 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      if (rand_bits(3) == 32'd0) begin
        cur_pc = {cur_pc[ADDR_W-1:LINE_OFS_W], 4'h0} + ((32'd16 + rand_bits(6)) << 4)
                 + (rand_bits(2) << 2);
        fetch_inst(cur_pc, 1'b1);
      end else begin
        cur_pc = cur_pc + 32'd4;
        fetch_inst(cur_pc, 1'b0);
      end
    end
    report_test();
  endtask

  initial begin
    lfsr_q    = 32'h896b;
    rst_n     = 1'b1;
    pc        = RESET_PC;
    jmp_flush = 1'b0;
    rdy_rand  = 1'b1;
    dly_rand  = 2'd0;
    rand_mode = 1'b0;
    fix_delay = 2'd0;
    cur_pc    = RESET_PC;
    last_pc   = RESET_PC;
    last_acc  = '0;
    jump_pend = 1'b1;
    jump_line = RESET_PC[ADDR_W-1:LINE_OFS_W];
    seen_cnt  = 0;
    check_cnt = 0;
    err_cnt   = 0;
    reset_check();
    sequential_fetch();
    prefetch_depth();
    jump_flush();
    random_stalls();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb_icache_model.sv ====
module tb_icache_model
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rdy_i,
  input  logic [1:0]        delay_i,
  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output logic [LINE_W-1:0] r_data_o,
  input  logic              r_ready_i,
  output int                acc_cnt_o,
  output logic [ADDR_W-1:0] acc_addr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic              busy_q;
  logic [1:0]        wait_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] line_base;

  // one read at a time, like the fetch side
  assign ar_ready_o = ~busy_q & rdy_i;
  assign r_valid_o  = busy_q & (wait_q == 2'd0);
  assign line_base  = {addr_q[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

  // word k of a line holds its own byte address
  always_comb begin
    for (int k = 0; k < LINE_W / INST_W; k++) begin
      r_data_o[k*INST_W +: INST_W] = line_base + INST_W'(4 * k);
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      busy_q     <= 1'b0;
      wait_q     <= 2'd0;
      addr_q     <= '0;
      acc_cnt_o  <= 0;
      acc_addr_o <= '0;
    end else if (!busy_q) begin
      if (ar_valid_i && ar_ready_o) begin
        busy_q     <= 1'b1;
        wait_q     <= delay_i;
        addr_q     <= ar_addr_i;
        acc_cnt_o  <= acc_cnt_o + 1;
        acc_addr_o <= ar_addr_i;
      end
    end else if (wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end else if (r_ready_i) begin
      busy_q <= 1'b0;
    end
  end

endmodule
